// File: spi_defs.svh
// defaults size a 64 entry register file and need SPI_SYNC_STAGES of 2 or more
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// ####################
// sizes
// ####################

`define SPI_PW 104  // fetch packet width in bits
`define SPI_AW 6    // register address width, matches the command address field

// ####################
// command opcodes
// ####################

// opcode sits in bits 7 and 6 of the command byte
`define SPI_OP_WR    2'b00  // write burst
`define SPI_OP_RD    2'b01  // read burst
`define SPI_OP_FETCH 2'b10  // remote fetch packet

// code 11 is unused, the slave then neither writes nor reads nor fetches

// ####################
// pin synchronizer
// ####################

`define SPI_SYNC_STAGES 2  // flops per spi pin

`endif

// File: spi_pkg.sv
// shared types of the spi slave, widths are taken from spi_defs.svh
`default_nettype none

`include "spi_defs.svh"

package spi_pkg;

   // ####################
   // data widths
   // ####################

   typedef logic [7:0]         spi_byte_t;    // one spi byte
   typedef logic [`SPI_AW-1:0] spi_addr_t;    // register file address
   typedef logic [1:0]         spi_op_t;      // command bits 7..6
   typedef logic [`SPI_PW-1:0] spi_packet_t;  // remote fetch packet

   // ####################
   // control fsm
   // ####################

   // one transaction per cs low period
   typedef enum logic [1:0] {
      st_idle,  // deselected
      st_cmd,   // command byte coming in
      st_data   // data bytes until cs rises
   } spi_state_t;

endpackage : spi_pkg

`default_nettype wire

// File: spi_pin_sync.sv
// spi_sck half period must be 4 sclk or more; spi_en, cpol, cpha stay static while selected
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_pin_sync (
   input  logic sclk,
   input  logic ss,
   input  logic spi_en,
   input  logic cpol,
   input  logic cpha,
   input  logic spi_sck,
   input  logic spi_cs_n,
   input  logic mosi,
   output logic cs_active,
   output logic cs_fall,
   output logic cs_rise,
   output logic sample_stb,
   output logic shift_stb,
   output logic mosi_s
);

   localparam int NS = `SPI_SYNC_STAGES;

   logic [NS-1:0] sck_q;       // sync chains, top bit is settled
   logic [NS-1:0] cs_q;
   logic [NS-1:0] mosi_q;
   logic          sck_d;       // settled sck, one cycle back
   logic          cs_d;        // settled cs_n, one cycle back
   logic          lead_edge;   // sck leaves its idle level
   logic          trail_edge;  // sck returns to idle level

   // ####################
   // synchronizers
   // ####################

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         sck_q <= '0;
         cs_q  <= '1;  // deselected out of reset
         sck_d <= 1'b0;
         cs_d  <= 1'b1;
      end else begin
         sck_q <= {sck_q[NS-2:0], spi_sck};
         cs_q  <= {cs_q[NS-2:0], spi_cs_n};
         sck_d <= sck_q[NS-1];
         cs_d  <= cs_q[NS-1];
      end
   end

   // mosi gets the same delay as sck so it lines up with sample_stb
   always_ff @(posedge sclk) begin
      mosi_q <= {mosi_q[NS-2:0], mosi};
      mosi_s <= mosi_q[NS-1];
   end

   // idle level is cpol, so leading edge is a fall when cpol is set
   assign lead_edge  = cpol ? (sck_d & ~sck_q[NS-1]) : (~sck_d & sck_q[NS-1]);
   assign trail_edge = cpol ? (~sck_d & sck_q[NS-1]) : (sck_d & ~sck_q[NS-1]);

   // ####################
   // strobes
   // ####################

   // registered, so pin to strobe is NS+1 cycles
   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         cs_active  <= 1'b0;
         cs_fall    <= 1'b0;
         cs_rise    <= 1'b0;
         sample_stb <= 1'b0;
         shift_stb  <= 1'b0;
      end else begin
         cs_fall    <= spi_en & ~cs_active & cs_d & ~cs_q[NS-1];
         cs_rise    <= spi_en & cs_active & ~cs_d & cs_q[NS-1];
         cs_active  <= spi_en & (cs_active | cs_fall) & ~cs_rise;  // tracks the ctrl fsm
         sample_stb <= spi_en & cs_active & (cpha ? trail_edge : lead_edge);
         shift_stb  <= spi_en & cs_active & (cpha ? lead_edge : trail_edge);
      end
   end

endmodule : spi_pin_sync

`default_nettype wire

// File: spi_shifter.sv
// rx_byte is only meaningful together with byte_done, packet_out is undefined until a capture
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_shifter
   import spi_pkg::*;
(
   input  logic        sclk,
   input  logic        ss,
   input  logic        lsbfirst,
   input  logic        cs_active,
   input  logic        cs_fall,
   input  logic        sample_stb,
   input  logic        shift_stb,
   input  logic        mosi_s,
   input  logic        tx_load,
   input  spi_byte_t   tx_load_data,
   input  logic        pkt_capture,
   output spi_byte_t   rx_byte,
   output logic        byte_done,
   output logic        miso,
   output spi_packet_t packet_out
);

   logic [2:0]  bit_cnt;   // bits of current byte seen
   spi_byte_t   rx_q;      // partial receive byte
   spi_packet_t pkt_sr;    // last SPI_PW mosi bits
   spi_byte_t   tx_sr;     // bits not yet on miso
   logic        tx_bit;    // bit currently on miso
   logic        tx_armed;  // first load of a transaction goes straight out

   // ####################
   // receive
   // ####################

   // combinational view of the byte including the bit being sampled
   assign rx_byte   = lsbfirst ? {mosi_s, rx_q[7:1]} : {rx_q[6:0], mosi_s};
   assign byte_done = sample_stb & (bit_cnt == 3'd7);

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         bit_cnt <= '0;
      end else if (cs_fall) begin
         bit_cnt <= '0;  // realign to byte 0
      end else if (sample_stb) begin
         bit_cnt <= bit_cnt + 3'd1;  // wraps every byte
      end
   end

   always_ff @(posedge sclk) begin
      if (sample_stb) begin
         rx_q   <= rx_byte;
         pkt_sr <= lsbfirst ? {mosi_s, pkt_sr[`SPI_PW-1:1]}
                            : {pkt_sr[`SPI_PW-2:0], mosi_s};
      end
      if (pkt_capture) begin
         packet_out <= pkt_sr;  // held copy for the valid/ready port
      end
   end

   // ####################
   // transmit
   // ####################

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         tx_armed <= 1'b0;
         tx_sr    <= '0;
         tx_bit   <= 1'b0;
      end else if (tx_load) begin
         tx_armed <= 1'b0;
         if (tx_armed) begin
            // cpha 0 needs bit 0 out before the first edge
            tx_bit <= lsbfirst ? tx_load_data[0] : tx_load_data[7];
            tx_sr  <= lsbfirst ? {1'b0, tx_load_data[7:1]} : {tx_load_data[6:0], 1'b0};
         end else begin
            tx_sr <= tx_load_data;  // goes out from the next shift edge
         end
      end else if (cs_fall) begin
         tx_armed <= 1'b1;
      end else if (shift_stb) begin
         tx_bit <= lsbfirst ? tx_sr[0] : tx_sr[7];
         tx_sr  <= lsbfirst ? {1'b0, tx_sr[7:1]} : {tx_sr[6:0], 1'b0};  // zero fill
      end
   end

   assign miso = cs_active & tx_bit;  // quiet while deselected

endmodule : spi_shifter

`default_nettype wire

// File: spi_regfile.sv
// 64 x 8 register file reachable only from spi, all entries read 00 after reset
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_regfile
   import spi_pkg::*;
(
   input  logic      sclk,
   input  logic      ss,
   input  logic      we,
   input  spi_addr_t waddr,
   input  spi_addr_t raddr,
   input  spi_byte_t wdata,
   output spi_byte_t rdata
);

   localparam int DEPTH = 1 << `SPI_AW;

   spi_byte_t mem [DEPTH];  // register storage

   // ####################
   // write port
   // ####################

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // ####################
   // read port
   // ####################

   // same cycle read, the ctrl loads it straight into the transmitter
   assign rdata = mem[raddr];

endmodule : spi_regfile

`default_nettype wire

// File: spi_slave_ctrl.sv
// one pending fetch packet at most, a fetch ending while pkt_valid is high is dropped
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_slave_ctrl
   import spi_pkg::*;
(
   input  logic      sclk,
   input  logic      ss,
   input  logic      cs_fall,
   input  logic      cs_rise,
   input  logic      byte_done,
   input  spi_byte_t rx_byte,
   input  spi_byte_t reg_rdata,
   input  logic      pkt_ready,
   output logic      reg_we,
   output spi_addr_t reg_addr,
   output spi_byte_t reg_wdata,
   output logic      tx_load,
   output spi_byte_t tx_load_data,
   output logic      pkt_capture,
   output logic      pkt_valid
);

   spi_state_t state;
   spi_op_t    op_q;       // opcode of this transaction
   spi_addr_t  addr_q;     // auto increment pointer
   spi_op_t    op_next;    // opcode that applies to the next byte
   logic       cmd_done;   // command byte complete
   logic       data_done;  // data byte complete
   logic       got_byte;   // at least one data byte seen
   logic       tx_rd;      // pending load takes register data

   assign cmd_done  = byte_done & (state == st_cmd);
   assign data_done = byte_done & (state == st_data);
   assign op_next   = cmd_done ? spi_op_t'(rx_byte[7:6]) : op_q;

   // ####################
   // fsm
   // ####################

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         state <= st_idle;
      end else if (cs_rise) begin
         state <= st_idle;  // abort from anywhere
      end else begin
         case (state)
            st_idle: if (cs_fall) state <= st_cmd;
            st_cmd:  if (byte_done) state <= st_data;
            st_data: state <= st_data;
            default: state <= st_idle;
         endcase
      end
   end

   // ####################
   // command and address
   // ####################

   // reads step on byte_done so the next byte is ready, writes step after the write
   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         op_q   <= `SPI_OP_WR;
         addr_q <= '0;
      end else if (cmd_done) begin
         op_q   <= rx_byte[7:6];
         addr_q <= rx_byte[`SPI_AW-1:0];
      end else if (reg_we | (data_done & (op_q != `SPI_OP_WR))) begin
         addr_q <= addr_q + spi_addr_t'(1);  // wraps at 64
      end
   end

   assign reg_addr = addr_q;

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         reg_we  <= 1'b0;
         tx_load <= 1'b0;
         tx_rd   <= 1'b0;
      end else begin
         reg_we  <= data_done & (op_q == `SPI_OP_WR);
         tx_load <= cs_fall | cmd_done | data_done;  // 00 unless reading
         tx_rd   <= (cmd_done | data_done) & (op_next == `SPI_OP_RD);
      end
   end

   always_ff @(posedge sclk) begin
      if (data_done) begin
         reg_wdata <= rx_byte;
      end
   end

   // addr_q already points at the byte to send
   assign tx_load_data = tx_rd ? reg_rdata : 8'h00;

   // ####################
   // fetch handshake
   // ####################

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         got_byte <= 1'b0;
      end else if (cs_fall) begin
         got_byte <= 1'b0;
      end else if (data_done) begin
         got_byte <= 1'b1;
      end
   end

   // shifter copies the packet on this cycle, pkt_valid follows next cycle
   assign pkt_capture = cs_rise & got_byte & (op_q == `SPI_OP_FETCH) & ~pkt_valid;

   always_ff @(posedge sclk or posedge ss) begin
      if (ss) begin
         pkt_valid <= 1'b0;
      end else if (pkt_capture) begin
         pkt_valid <= 1'b1;
      end else if (pkt_ready) begin
         pkt_valid <= 1'b0;  // accepted
      end
   end

endmodule : spi_slave_ctrl

`default_nettype wire

// File: spi_slave_top.sv
// spi pins are oversampled in sclk, mode and enable inputs must not change while cs is low
`timescale 1ns/1ps
`default_nettype none

module spi_slave_top
   import spi_pkg::*;
(
   input  logic        sclk,
   input  logic        ss,
   input  logic        spi_en,
   input  logic        cpol,
   input  logic        cpha,
   input  logic        lsbfirst,
   input  logic        spi_sck,
   input  logic        spi_cs_n,
   input  logic        mosi,
   output logic        miso,
   output spi_packet_t packet_out,
   output logic        pkt_valid,
   input  logic        pkt_ready
);

   // ####################
   // internal nets
   // ####################

   logic      cs_active;
   logic      cs_fall;
   logic      cs_rise;
   logic      sample_stb;
   logic      shift_stb;
   logic      mosi_s;        // synchronized mosi
   spi_byte_t rx_byte;
   logic      byte_done;
   logic      tx_load;
   spi_byte_t tx_load_data;
   logic      pkt_capture;
   logic      reg_we;
   spi_addr_t reg_addr;      // shared by both regfile ports
   spi_byte_t reg_wdata;
   spi_byte_t reg_rdata;

   spi_pin_sync u_pin_sync (
      .sclk,
      .ss,
      .spi_en,
      .cpol,
      .cpha,
      .spi_sck,
      .spi_cs_n,
      .mosi,
      .cs_active,
      .cs_fall,
      .cs_rise,
      .sample_stb,
      .shift_stb,
      .mosi_s
   );

   spi_shifter u_shifter (
      .sclk,
      .ss,
      .lsbfirst,
      .cs_active,
      .cs_fall,
      .sample_stb,
      .shift_stb,
      .mosi_s,
      .tx_load,
      .tx_load_data,
      .pkt_capture,
      .rx_byte,
      .byte_done,
      .miso,
      .packet_out
   );

   spi_regfile u_regfile (
      .sclk,
      .ss,
      .we    (reg_we),
      .waddr (reg_addr),
      .raddr (reg_addr),
      .wdata (reg_wdata),
      .rdata (reg_rdata)
   );

   spi_slave_ctrl u_ctrl (
      .sclk,
      .ss,
      .cs_fall,
      .cs_rise,
      .byte_done,
      .rx_byte,
      .reg_rdata,
      .pkt_ready,
      .reg_we,
      .reg_addr,
      .reg_wdata,
      .tx_load,
      .tx_load_data,
      .pkt_capture,
      .pkt_valid
   );

endmodule : spi_slave_top

`default_nettype wire

// File: spi_slave_asserts.sv
// bound into every spi_slave_ctrl, all checks are off while ss is high
`timescale 1ns/1ps
`default_nettype none

module spi_slave_asserts
   import spi_pkg::*;
(
   input logic       sclk,
   input logic       ss,
   input spi_state_t state,
   input logic       cs_fall,
   input logic       reg_we,
   input logic       pkt_valid,
   input logic       pkt_ready
);

   int fails = 0;  // read by the bench at the end

   // ####################
   // fetch handshake
   // ####################

   a_valid_held: assert property (@(posedge sclk) disable iff (ss)
      pkt_valid && !pkt_ready |=> pkt_valid)
   else begin
      $error("pkt_valid fell before the handshake");
      fails++;
   end

   // ####################
   // fsm
   // ####################

   a_we_in_data: assert property (@(posedge sclk) disable iff (ss)
      reg_we |-> state == st_data)
   else begin
      $error("register write outside the data phase");
      fails++;
   end

   // cs_fall only comes while deselected, fsm must be back in idle by then
   a_idle_at_select: assert property (@(posedge sclk) disable iff (ss)
      cs_fall |-> state == st_idle)
   else begin
      $error("fsm was not idle when a new transaction started");
      fails++;
   end

endmodule : spi_slave_asserts

bind spi_slave_ctrl spi_slave_asserts u_asserts (
   .sclk      (sclk),
   .ss        (ss),
   .state     (state),
   .cs_fall   (cs_fall),
   .reg_we    (reg_we),
   .pkt_valid (pkt_valid),
   .pkt_ready (pkt_ready)
);

`default_nettype wire

// File: tb_clkgen.sv
// 100 MHz clock from time 0, reset released on a falling edge after 16 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic sclk,
   output logic ss
);

   localparam int RESET_CYCLES = 16;

   initial begin
      sclk = 1'b0;
      forever #5 sclk = ~sclk;  // 10 ns period
   end

   initial begin
      ss = 1'b1;
      repeat (RESET_CYCLES) @(posedge sclk);
      @(negedge sclk);
      ss = 1'b0;  // away from the active edge
   end

endmodule : tb_clkgen

`default_nettype wire

// File: tb_checker.sv
// expected packets must be queued before the transaction that makes them
`timescale 1ns/1ps
`default_nettype none

module tb_checker
   import spi_pkg::*;
(
   input  logic        sclk,
   input  logic        ss,
   input  logic        rd_stb,       // one cycle per read byte
   input  spi_byte_t   rd_byte,      // byte the master saw on miso
   input  spi_byte_t   rd_exp,
   input  logic        exp_pkt_stb,  // queue one expected packet
   input  spi_packet_t exp_pkt,
   input  logic        pkt_valid,
   input  logic        pkt_ready,
   input  spi_packet_t packet_out,
   input  logic        end_check,    // final sweep of the queue
   output int          errors,
   output int          reads,
   output int          packets
);

   spi_packet_t exp_q [$];  // packets still to be accepted
   spi_packet_t held;       // packet_out of the last cycle
   logic        held_ok;    // last cycle offered without handshake

   always @(posedge sclk) begin
      if (ss) begin
         errors  = 0;
         reads   = 0;
         packets = 0;
         held_ok = 1'b0;
         exp_q.delete();
      end else begin
         if (exp_pkt_stb) exp_q.push_back(exp_pkt);

         // ####################
         // miso bytes
         // ####################
         if (rd_stb) begin
            reads++;
            if (rd_byte !== rd_exp) begin
               errors++;
               $display("error miso: byte %0d got %h expected %h", reads, rd_byte, rd_exp);
            end
         end

         // ####################
         // fetch port
         // ####################
         if (held_ok && pkt_valid && packet_out !== held) begin
            errors++;
            $display("error packet_out: changed while held, got %h expected %h",
                     packet_out, held);
         end
         held_ok = pkt_valid & ~pkt_ready;
         held    = packet_out;

         if (pkt_valid && pkt_ready) begin
            packets++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("a packet was accepted although none was expected");
            end else begin
               if (packet_out !== exp_q[0]) begin
                  errors++;
                  $display("error packet_out: got %h expected %h", packet_out, exp_q[0]);
               end
               exp_q.delete(0);
            end
         end

         if (end_check && exp_q.size() != 0) begin
            errors += exp_q.size();
            $display("%0d expected packets were never accepted", exp_q.size());
            exp_q.delete();
         end
      end
   end

endmodule : tb_checker

`default_nettype wire

// File: tb_spi_slave.sv
// master model at 16 sclk per spi bit, spi_golden.txt must close with an ff record
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module tb_spi_slave
   import spi_pkg::*;
();

   localparam int HALF      = 8;           // sclk cycles per spi_sck half period
   localparam int GOLD_MAX  = 1024;
   localparam int PKT_BYTES = `SPI_PW / 8;

   logic        sclk;
   logic        ss;
   logic        spi_en;
   logic        cpol;
   logic        cpha;
   logic        lsbfirst;
   logic        spi_sck;
   logic        spi_cs_n;
   logic        mosi;
   logic        miso;
   spi_packet_t packet_out;
   logic        pkt_valid;
   logic        pkt_ready;

   logic        rd_stb;
   spi_byte_t   rd_byte;
   spi_byte_t   rd_exp;
   logic        exp_pkt_stb;
   spi_packet_t exp_pkt;
   logic        end_check;
   int          chk_errors;
   int          chk_reads;
   int          chk_pkts;

   logic [7:0]  gold [0:GOLD_MAX-1];  // flat record stream
   int          seed = 32'h081b6154;
   int          hold_cnt;      // lines left with pkt_ready forced low
   int          n_lines;
   int          bench_errors;
   logic        lines_known = 1'b0;

   tb_clkgen u_clk (
      .sclk,
      .ss
   );

   spi_slave_top uut (
      .sclk,
      .ss,
      .spi_en,
      .cpol,
      .cpha,
      .lsbfirst,
      .spi_sck,
      .spi_cs_n,
      .mosi,
      .miso,
      .packet_out,
      .pkt_valid,
      .pkt_ready
   );

   tb_checker u_chk (
      .sclk,
      .ss,
      .rd_stb,
      .rd_byte,
      .rd_exp,
      .exp_pkt_stb,
      .exp_pkt,
      .pkt_valid,
      .pkt_ready,
      .packet_out,
      .end_check,
      .errors  (chk_errors),
      .reads   (chk_reads),
      .packets (chk_pkts)
   );

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge sclk);
   endtask

   // payload bytes after the 4 byte record head
   function automatic int rec_len(input logic [7:0] cnt, input logic [7:0] chk);
      int extra;
      extra = (chk == 8'h01) ? int'(cnt) : ((chk == 8'h02) ? PKT_BYTES : 0);
      return int'(cnt) + extra;
   endfunction

   // ####################
   // spi master
   // ####################

   task automatic spi_byte(input spi_byte_t tx, output spi_byte_t rx);
      int idx;
      for (int i = 0; i < 8; i++) begin
         idx = lsbfirst ? i : 7 - i;
         mosi = tx[idx];
         if (!cpha) begin
            wait_cycles(HALF);
            rx[idx] = miso;      // sample on leading edge
            spi_sck = ~cpol;
            wait_cycles(HALF);
            spi_sck = cpol;
         end else begin
            spi_sck = ~cpol;     // data changes with leading edge
            wait_cycles(HALF);
            rx[idx] = miso;
            spi_sck = cpol;
            wait_cycles(HALF);
         end
      end
   endtask

   task automatic run_line(inout int p);
      spi_byte_t   mode;
      spi_byte_t   cmd;
      spi_byte_t   rx;
      spi_byte_t   rx_q [$];
      spi_packet_t pkt;
      int          cnt;
      int          chk;
      mode = gold[p];
      cmd  = gold[p+1];
      cnt  = int'(gold[p+2]);
      chk  = int'(gold[p+3]);
      p    = p + 4;
      cpha     = mode[0];  // mode pins move only while deselected
      cpol     = mode[1];
      lsbfirst = mode[2];
      spi_sck  = mode[1];  // idle level
      if (mode[3]) hold_cnt = 2;
      if (chk == 2) begin
         pkt = '0;
         for (int k = 0; k < PKT_BYTES; k++) begin
            pkt = {pkt[`SPI_PW-9:0], gold[p+cnt+k]};  // top byte listed first
         end
         exp_pkt     = pkt;
         exp_pkt_stb = 1'b1;
         wait_cycles(1);
         exp_pkt_stb = 1'b0;
      end
      wait_cycles(HALF);
      spi_cs_n = 1'b0;
      wait_cycles(HALF);
      spi_byte(cmd, rx);
      for (int k = 0; k < cnt; k++) begin
         spi_byte(gold[p+k], rx);
         rx_q.push_back(rx);
      end
      wait_cycles(HALF);
      spi_cs_n = 1'b1;
      mosi     = 1'b0;
      p        = p + cnt;
      if (chk == 1) begin
         for (int k = 0; k < cnt; k++) begin
            rd_byte = rx_q[k];
            rd_exp  = gold[p+k];
            rd_stb  = 1'b1;
            wait_cycles(1);
         end
         rd_stb = 1'b0;
         p      = p + cnt;
      end else if (chk == 2) begin
         p = p + PKT_BYTES;
      end
      wait_cycles(2 * HALF);  // room for pkt_valid to rise
      if (hold_cnt > 0) hold_cnt = hold_cnt - 1;
      while (hold_cnt == 0 && pkt_valid) wait_cycles(1);
   endtask

   // ####################
   // pkt_ready stimulus
   // ####################

   initial begin
      int rnd;
      pkt_ready = 1'b0;
      forever begin
         @(negedge sclk);
         rnd       = $random(seed);
         pkt_ready = (hold_cnt == 0) & rnd[0];  // back-pressure window forces 0
      end
   end

   // ####################
   // main sequence
   // ####################

   initial begin
      int p;
      int total;
      spi_en       = 1'b1;
      cpol         = 1'b0;
      cpha         = 1'b0;
      lsbfirst     = 1'b0;
      spi_sck      = 1'b0;
      spi_cs_n     = 1'b1;
      mosi         = 1'b0;
      rd_stb       = 1'b0;
      rd_byte      = '0;
      rd_exp       = '0;
      exp_pkt_stb  = 1'b0;
      exp_pkt      = '0;
      end_check    = 1'b0;
      hold_cnt     = 0;
      bench_errors = 0;
      n_lines      = 0;
      $readmemh("spi_golden.txt", gold);
      p = 0;
      while (p < GOLD_MAX - 4 && gold[p] != 8'hff && gold[p+2] != 8'h00) begin
         n_lines = n_lines + 1;
         p       = p + 4 + rec_len(gold[p+2], gold[p+3]);
      end
      if (p >= GOLD_MAX - 4 || gold[p] !== 8'hff || n_lines == 0) begin
         $display("golden file is empty or has no ff end record");
         bench_errors++;
      end
      lines_known = 1'b1;

      while (ss) wait_cycles(1);
      wait_cycles(4);
      p = 0;
      for (int l = 0; l < n_lines; l++) begin
         run_line(p);
      end

      end_check = 1'b1;
      wait_cycles(1);
      end_check = 1'b0;
      wait_cycles(2);
      total = chk_errors + bench_errors + uut.u_ctrl.u_asserts.fails;
      $display("%0d miso bytes and %0d packets checked, %0d errors (%0d data, %0d assert, %0d tb)",
               chk_reads, chk_pkts, total, chk_errors, uut.u_ctrl.u_asserts.fails,
               bench_errors);
      if (total == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // ####################
   // watchdog
   // ####################

   initial begin
      real limit_ns;
      wait (lines_known);
      limit_ns = n_lines * 120 * 16 * 10.0 + 10000.0;  // 120 bits of 16 cycles per line
      #(limit_ns);
      $display("timeout, the run did not finish within %0.0f ns", limit_ns);
      $display("Test FAILED");
      $finish;
   end

endmodule : tb_spi_slave

`default_nettype wire

// File: spi_golden.txt
// mode cmd cnt chk, cnt mosi bytes, then cnt miso bytes (chk 01) or packet from bit 103 (chk 02)
// mode bits: 0 cpha, 1 cpol, 2 lsbfirst, 3 pkt_ready low through this and the next line
00 05 04 00 11 22 33 44
00 45 04 01 00 00 00 00 11 22 33 44
00 3e 04 00 a1 b2 c3 d4
00 7e 05 01 00 00 00 00 00 a1 b2 c3 d4 00
01 10 03 00 5a a5 3c
02 50 03 01 ff ff ff 5a a5 3c
07 20 02 00 81 7e
05 60 03 01 00 00 00 81 7e 00
03 7f 03 01 00 00 00 b2 c3 d4
00 80 0d 02 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d
07 80 0d 02 f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc fc fb fa f9 f8 f7 f6 f5 f4 f3 f2 f1 f0
09 80 0d 02 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 10 11 12 13 14 15 16 17 18 19 1a 1b 1c
// fetch ending while the packet above is held, no packet expected
02 80 0d 00 e0 e1 e2 e3 e4 e5 e6 e7 e8 e9 ea eb ec
ff

// File: sim.f
+incdir+.
spi_pkg.sv
spi_pin_sync.sv
spi_shifter.sv
spi_regfile.sv
spi_slave_ctrl.sv
spi_slave_top.sv
spi_slave_asserts.sv
tb_clkgen.sv
tb_checker.sv
tb_spi_slave.sv

// File: run_sim.sh
#!/bin/sh
# build and run from the project root, status follows the testbench verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   -f sim.f --top-module tb_spi_slave -o tb_spi_slave \
   && ./obj_dir/tb_spi_slave +verilator+error+limit+100 | tee /dev/stderr | grep -q "Test OK" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
